//--- hw/video_pkg.sv
package video_pkg;

	// decoder byte stream and pixel words
	typedef logic [7:0]  vbyte_t;            // one byte off the decoder bus
	typedef logic [15:0] rgb565_t;           // r5 g6 b5
	typedef logic [4:0]  gray_t;             // gray level, red field width

	// fixed point for the colour conversion
	typedef logic signed [20:0] fix_t;       // product and sum width
	typedef logic [9:0]         coef_t;      // 2.8 unsigned coefficient

	// ITU-R 601 style factors scaled by 256
	localparam coef_t C_Y  = 10'd298;        // 1.164
	localparam coef_t C_RV = 10'd409;        // 1.596
	localparam coef_t C_GV = 10'd208;        // 0.813
	localparam coef_t C_GU = 10'd100;        // 0.392
	localparam coef_t C_BU = 10'd516;        // 2.017

	// offsets on a byte widened by two zero bits
	localparam fix_t Y_OFS = 21'sd64;        // 16 << 2
	localparam fix_t C_OFS = 21'sd512;       // 128 << 2

	// --------------------
	// line and field geometry
	localparam int BYTES_PER_PAIR = 4;       // cb y0 cr y1
	localparam int PAIR_KEEP      = 2;       // one pair in two along a line
	localparam int LINE_KEEP      = 2;       // one line in two of the field

	localparam int FRAME_W = 180;
	localparam int FRAME_H = 120;            // bank holds FRAME_W * FRAME_H words

	typedef logic [9:0] pix_cnt_t;           // pair index in a line
	typedef logic [8:0] line_cnt_t;          // line index in a field

endpackage

//--- hw/membus_pkg.sv
package membus_pkg;

	typedef logic [15:0] word_t;             // one frame RAM word
	typedef logic [15:0] maddr_t;            // full RAM address, both banks
	typedef logic [14:0] haddr_t;            // host word address inside a bank

	localparam int BANK_BIT = 15;            // top RAM address bit picks the bank

	// video write request, held stable while req is high
	typedef struct packed {
		maddr_t addr;
		word_t  data;
	} wr_req_t;

	// --------------------
	// arbiter states
	typedef enum logic [2:0] {
		IDLE,                                // nothing in progress
		VWRITE,                              // RAM write strobe
		VDONE,                               // ack up, wait for req to drop
		HREAD,                               // host address on the RAM
		HHOLD                                // host data ready, wait for rdx
	} arb_state_t;

	localparam int IRQ_CYCLES = 2;           // frame end pulse length

endpackage

//--- hw/capture_timing.sv
`timescale 1ns/1ps

module capture_timing (
	input  logic              clk_llc,
	input  logic              resetx,
	input  logic              vref,
	input  logic              href,
	input  logic              odd,
	input  video_pkg::vbyte_t vpo,
	output logic [1:0]        byte_phase,
	output logic              keep_pair,
	output video_pkg::vbyte_t vbyte,
	output logic              field_active
);
	import video_pkg::*;

	logic      href_r;      // href aligned with vbyte
	logic      href_d;      // previous href_r, for the line edge
	logic [1:0] byte_cnt;
	pix_cnt_t  pair_cnt;
	line_cnt_t line_cnt;

	// input register, the byte itself carries no control
	always_ff @(posedge clk_llc)
		vbyte <= vpo;

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			href_r       <= 1'b0;
			href_d       <= 1'b0;
			field_active <= 1'b0;
			byte_cnt     <= '0;
			pair_cnt     <= '0;
			line_cnt     <= '1;
		end
		else
		begin
			href_r       <= href;
			href_d       <= href_r;
			field_active <= vref & odd;          // odd field only
			// byte and pair position, cleared in horizontal blank
			if (!href_r)
			begin
				byte_cnt <= '0;
				pair_cnt <= '0;
			end
			else
			begin
				byte_cnt <= (byte_cnt == 2'(BYTES_PER_PAIR - 1)) ? '0 : byte_cnt + 2'd1;
				if (byte_cnt == 2'(BYTES_PER_PAIR - 1))
					pair_cnt <= pair_cnt + 1'b1;
			end
			// all ones outside the field, so the first line counts as 0
			if (!field_active)
				line_cnt <= '1;
			else if (href_r && !href_d)
				line_cnt <= line_cnt + 1'b1;
		end
	end

	assign byte_phase = byte_cnt;

	// on the y1 byte of an even pair in an even line
	assign keep_pair = field_active & href_r & (byte_cnt == 2'(BYTES_PER_PAIR - 1)) &
		(pair_cnt % PAIR_KEEP == 0) & (line_cnt % LINE_KEEP == 0);

endmodule

//--- hw/ycbcr_convert.sv
`timescale 1ns/1ps

module ycbcr_convert (
	input  logic               clk_llc,
	input  logic               resetx,
	input  video_pkg::vbyte_t  vbyte,
	input  logic [1:0]         byte_phase,
	input  logic               keep_pair,
	output logic               pix_valid,
	output video_pkg::rgb565_t pix_word
);
	import video_pkg::*;

	vbyte_t     cb_r;
	vbyte_t     y0_r;
	vbyte_t     cr_r;
	fix_t       x_p;         // stage 1 products
	fix_t       a_p;
	fix_t       g1_p;
	fix_t       g2_p;
	fix_t       bc_p;
	fix_t       r_s;         // stage 2 sums
	fix_t       g_s;
	fix_t       b_s;
	logic [5:0] r_c;
	logic [5:0] g_c;
	logic [5:0] b_c;
	gray_t      gray;
	logic       v1;
	logic       v2;

	// coefficient times (byte*4 - offset)
	function automatic fix_t scale(input coef_t c, input vbyte_t v, input fix_t ofs);
		fix_t diff;
		diff = fix_t'({v, 2'b00}) - ofs;
		return fix_t'({1'b0, c}) * diff;
	endfunction

	// bits 17:12 with floor at 0 and saturation above bit 17
	function automatic logic [5:0] clamp6(input fix_t v);
		logic [5:0] res;
		if (v[20])
			res = '0;
		else if (v[19:18] != 2'b00)
			res = '1;
		else
			res = v[17:12];
		return res;
	endfunction

	// --------------------
	// datapath, payload only
	always_ff @(posedge clk_llc)
	begin
		case (byte_phase)
			2'd0: cb_r <= vbyte;
			2'd1: y0_r <= vbyte;
			2'd2: cr_r <= vbyte;
			default: ;                           // y1 not needed
		endcase
		if (keep_pair)                           // y1 cycle, cr already latched
		begin
			x_p  <= scale(C_Y,  y0_r, Y_OFS);
			a_p  <= scale(C_RV, cr_r, C_OFS);
			g1_p <= scale(C_GV, cr_r, C_OFS);
			g2_p <= scale(C_GU, cb_r, C_OFS);
			bc_p <= scale(C_BU, cb_r, C_OFS);
		end
		if (v1)
		begin
			r_s <= x_p + a_p;
			g_s <= x_p - g1_p - g2_p;
			b_s <= x_p + bc_p;
		end
		if (v2)
			pix_word <= {gray, gray, 1'b0, gray};
	end

	// r and b use the upper five of the same six bits
	assign r_c  = clamp6(r_s);
	assign g_c  = clamp6(g_s);
	assign b_c  = clamp6(b_s);
	assign gray = gray_t'(r_c[5:3]) + gray_t'(g_c[5:2]) + gray_t'(b_c[5:4]);  // r/4 + g/4 + b/8

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			v1        <= 1'b0;
			v2        <= 1'b0;
			pix_valid <= 1'b0;
		end
		else
		begin
			v1        <= keep_pair;
			v2        <= v1;
			pix_valid <= v2;                     // keep_pair + 3
		end
	end

endmodule

//--- hw/frame_writer.sv
`timescale 1ns/1ps

module frame_writer (
	input  logic                clk_llc,
	input  logic                resetx,
	input  logic                field_active,
	input  logic                pix_valid,
	input  video_pkg::rgb565_t  pix_word,
	output membus_pkg::wr_req_t wr,
	output logic                wr_req,
	input  logic                wr_ack,
	output logic                read_bank,
	output logic                irq0,
	output logic                irq1
);
	import video_pkg::*;
	import membus_pkg::*;

	logic       bank;        // bank being filled
	haddr_t     waddr;       // word offset inside the bank
	logic       field_d;
	logic       pend;        // word latched, req not yet raised
	logic [1:0] irq_cnt;
	logic       frame_end;
	logic       accept;
	logic       start;

	assign frame_end = field_d & ~field_active;
	assign accept    = pix_valid & (waddr < haddr_t'(FRAME_W * FRAME_H));  // drop past bank end
	assign start     = (accept | pend) & ~wr_req & ~wr_ack;   // four phase, ack must be low

	always_ff @(posedge clk_llc)
		if (accept)
			wr <= '{addr: maddr_t'({bank, waddr}), data: pix_word};

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			field_d   <= 1'b0;
			wr_req    <= 1'b0;
			pend      <= 1'b0;
			bank      <= 1'b0;
			read_bank <= 1'b0;
			waddr     <= '0;
			irq_cnt   <= '0;
		end
		else
		begin
			field_d <= field_active;
			pend    <= (accept | pend) & ~start;
			if (start)
				wr_req <= 1'b1;
			else if (wr_ack)
				wr_req <= 1'b0;              // ack seen, release
			// --------------------
			// frame end, swap banks
			if (frame_end)
			begin
				bank      <= ~bank;
				read_bank <= bank;           // finished bank goes to the host
				waddr     <= '0;
				irq_cnt   <= 2'(IRQ_CYCLES);
			end
			else
			begin
				if (accept)
					waddr <= waddr + 1'b1;
				if (irq_cnt != '0)
					irq_cnt <= irq_cnt - 2'd1;
			end
		end
	end

	assign irq0 = (irq_cnt != '0) & read_bank;   // bank 1 done
	assign irq1 = (irq_cnt != '0) & ~read_bank;  // bank 0 done

endmodule

//--- hw/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
	input  logic                clk_llc,
	input  logic                resetx,
	input  membus_pkg::wr_req_t wr,
	input  logic                wr_req,
	output logic                wr_ack,
	input  logic                read_bank,
	input  logic                csx,
	input  logic                rdx,
	input  membus_pkg::haddr_t  haddr,
	output membus_pkg::word_t   rd_data,
	output logic                waitx,
	output membus_pkg::maddr_t  ram_addr,
	output logic                ram_we,
	output membus_pkg::word_t   ram_wdata,
	input  membus_pkg::word_t   ram_rdata
);
	import membus_pkg::*;

	arb_state_t state;
	arb_state_t state_nx;
	logic       rd_valid;    // rd_data holds this access's word
	logic       host_rd;
	maddr_t     host_addr;

	assign host_rd = ~csx & ~rdx & ~rd_valid;

	// host reads always go to the last finished bank
	always_comb
	begin
		host_addr                 = '0;
		host_addr[BANK_BIT]       = read_bank;
		host_addr[BANK_BIT - 1:0] = haddr;
	end

	// --------------------
	// next state, video first
	always_comb
	begin
		state_nx = state;
		case (state)
			IDLE:   if (wr_req) state_nx = VWRITE;
				else if (host_rd) state_nx = HREAD;
			VWRITE: state_nx = VDONE;
			VDONE:  if (!wr_req) state_nx = IDLE;      // req dropped, ack follows
			HREAD:  state_nx = HHOLD;
			HHOLD:  if (wr_req) state_nx = VWRITE;     // ram is free here
				else if (csx || rdx) state_nx = IDLE;
			default: state_nx = IDLE;
		endcase
	end

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			state    <= IDLE;
			rd_valid <= 1'b0;
			rd_data  <= '0;
		end
		else
		begin
			state <= state_nx;
			if (csx || rdx)
				rd_valid <= 1'b0;               // strobe gone, access over
			else if (state == HHOLD && !rd_valid)
			begin
				rd_valid <= 1'b1;
				rd_data  <= ram_rdata;          // registered read from HREAD
			end
		end
	end

	assign ram_we    = (state == VWRITE);
	assign ram_addr  = ram_we ? wr.addr : host_addr;
	assign ram_wdata = wr.data;
	assign wr_ack    = (state == VDONE);
	assign waitx     = csx | rdx | rd_valid;  // low only while a read is pending

endmodule

//--- hw/frame_ram.sv
`timescale 1ns/1ps

module frame_ram (
	input  logic               clk_llc,
	input  membus_pkg::maddr_t ram_addr,
	input  logic               ram_we,
	input  membus_pkg::word_t  ram_wdata,
	output membus_pkg::word_t  ram_rdata
);
	import membus_pkg::*;

	// two banks of 32K words, split by BANK_BIT
	word_t mem [0:(1 << $bits(maddr_t)) - 1];

	// single port, read data one cycle later
	always_ff @(posedge clk_llc)
	begin
		if (ram_we)
			mem[ram_addr] <= ram_wdata;
		ram_rdata <= mem[ram_addr];          // old word on a write cycle
	end

endmodule

//--- hw/video_capture_top.sv
`timescale 1ns/1ps

module video_capture_top (
	input  logic               clk_llc,
	input  logic               resetx,
	input  logic               vref,
	input  logic               href,
	input  logic               odd,
	input  video_pkg::vbyte_t  vpo,
	input  logic               csx,
	input  logic               rdx,
	input  membus_pkg::haddr_t haddr,
	output membus_pkg::word_t  rd_data,
	output logic               waitx,
	output logic               irq0,
	output logic               irq1
);
	import video_pkg::*;
	import membus_pkg::*;

	// --------------------
	// capture side
	logic [1:0] byte_phase;
	logic       keep_pair;
	vbyte_t     vbyte;
	logic       field_active;
	logic       pix_valid;
	rgb565_t    pix_word;

	// memory side
	wr_req_t    wr;
	logic       wr_req;
	logic       wr_ack;
	logic       read_bank;
	maddr_t     ram_addr;
	logic       ram_we;
	word_t      ram_wdata;
	word_t      ram_rdata;

	capture_timing u_timing (
		.clk_llc(clk_llc), .resetx(resetx), .vref(vref), .href(href), .odd(odd),
		.vpo(vpo), .byte_phase(byte_phase), .keep_pair(keep_pair), .vbyte(vbyte),
		.field_active(field_active));

	ycbcr_convert u_convert (
		.clk_llc(clk_llc), .resetx(resetx), .vbyte(vbyte), .byte_phase(byte_phase),
		.keep_pair(keep_pair), .pix_valid(pix_valid), .pix_word(pix_word));

	frame_writer u_writer (
		.clk_llc(clk_llc), .resetx(resetx), .field_active(field_active),
		.pix_valid(pix_valid), .pix_word(pix_word), .wr(wr), .wr_req(wr_req),
		.wr_ack(wr_ack), .read_bank(read_bank), .irq0(irq0), .irq1(irq1));

	mem_arbiter u_arbiter (
		.clk_llc(clk_llc), .resetx(resetx), .wr(wr), .wr_req(wr_req), .wr_ack(wr_ack),
		.read_bank(read_bank), .csx(csx), .rdx(rdx), .haddr(haddr), .rd_data(rd_data),
		.waitx(waitx), .ram_addr(ram_addr), .ram_we(ram_we), .ram_wdata(ram_wdata),
		.ram_rdata(ram_rdata));

	frame_ram u_ram (
		.clk_llc(clk_llc), .ram_addr(ram_addr), .ram_we(ram_we),
		.ram_wdata(ram_wdata), .ram_rdata(ram_rdata));

endmodule

//--- bench/video_capture_asserts.sv
`timescale 1ns/1ps

module video_capture_asserts (
	input logic clk_llc,
	input logic resetx,
	input logic wr_req,
	input logic wr_ack,
	input logic irq0,
	input logic irq1
);
	import membus_pkg::*;

	int fail_cnt = 0;        // failed assertions so far

	// four phase handshake, req held until ack
	req_held: assert property (@(posedge clk_llc) disable iff (!resetx)
		wr_req && !wr_ack |=> wr_req)
	else
	begin
		$error("wr_req dropped before wr_ack was raised");
		fail_cnt++;
	end

	// only one bank finishes at a time
	irq_exclusive: assert property (@(posedge clk_llc) disable iff (!resetx)
		!(irq0 && irq1))
	else
	begin
		$error("irq0 and irq1 high in the same cycle");
		fail_cnt++;
	end

	// --------------------
	// pulse length
	irq0_len: assert property (@(posedge clk_llc) disable iff (!resetx)
		$rose(irq0) |-> irq0 [*IRQ_CYCLES] ##1 !irq0)
	else
	begin
		$error("irq0 pulse length differs from IRQ_CYCLES");
		fail_cnt++;
	end

	irq1_len: assert property (@(posedge clk_llc) disable iff (!resetx)
		$rose(irq1) |-> irq1 [*IRQ_CYCLES] ##1 !irq1)
	else
	begin
		$error("irq1 pulse length differs from IRQ_CYCLES");
		fail_cnt++;
	end

endmodule

bind video_capture_top video_capture_asserts u_asserts (
	.clk_llc(clk_llc), .resetx(resetx), .wr_req(wr_req), .wr_ack(wr_ack),
	.irq0(irq0), .irq1(irq1));

//--- bench/tb_video_capture.sv
`timescale 1ns/1ps

module tb_video_capture;
	import video_pkg::*;
	import membus_pkg::*;

	localparam int LINES      = 8;       // lines per test field
	localparam int PAIRS      = 16;      // pairs per line
	localparam int KEPT_WORDS = 32;      // 4 kept lines x 8 kept pairs
	localparam int READ_LIMIT = 64;      // cycles a single host read may take
	// five fields near 600 cycles each plus four readbacks near 200 make about 4000
	localparam int MAX_CYCLES = 20000;

	logic   clk_llc;
	logic   resetx;
	logic   vref;
	logic   href;
	logic   odd;
	vbyte_t vpo;
	logic   csx;
	logic   rdx;
	haddr_t haddr;
	word_t  rd_data;
	logic   waitx;
	logic   irq0;
	logic   irq1;

	word_t bank_exp [2][KEPT_WORDS];     // expected contents of each bank
	logic  fill_bank;                    // bank the next odd field goes to
	logic  done_bank;                    // last completed bank
	int    cycle_cnt = 0;

	video_capture_top DUT (
		.clk_llc(clk_llc), .resetx(resetx), .vref(vref), .href(href), .odd(odd),
		.vpo(vpo), .csx(csx), .rdx(rdx), .haddr(haddr), .rd_data(rd_data),
		.waitx(waitx), .irq0(irq0), .irq1(irq1));

	initial
	begin
		clk_llc = 1'b0;
		forever #20 clk_llc = ~clk_llc;  // 40 ns period
	end

	always @(posedge clk_llc)
	begin
		cycle_cnt++;
		if (DUT.u_asserts.fail_cnt != 0)
			abort_run("a protocol assertion failed during the run");
		else if (cycle_cnt >= MAX_CYCLES)
			abort_run("simulation ran past the cycle limit, a test is stuck");
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check_value(input string test, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
			abort_run($sformatf("Error: %s expected 0x%0h actual 0x%0h", test, exp, act));
	endtask

	task automatic next_cycle();
		@(posedge clk_llc);
		#2;                              // inputs change clear of the edge
	endtask

	// --------------------
	// conversion model
	function automatic int clamp_bits(input int v, input int lsb);
		int res;
		if (v < 0)
			res = 0;                     // floor
		else if (v[19:18] != 2'b00)
			res = (1 << (18 - lsb)) - 1; // saturate to all ones
		else
			res = (v >> lsb) & ((1 << (18 - lsb)) - 1);
		return res;
	endfunction

	function automatic word_t model_pixel(input vbyte_t cb, input vbyte_t y0, input vbyte_t cr);
		int x;
		int a;
		int g1;
		int g2;
		int bc;
		int r5;
		int g6;
		int b5;
		logic [4:0] gray;
		x    = 298 * (4 * int'(y0) - 64);
		a    = 409 * (4 * int'(cr) - 512);
		g1   = 208 * (4 * int'(cr) - 512);
		g2   = 100 * (4 * int'(cb) - 512);
		bc   = 516 * (4 * int'(cb) - 512);
		r5   = clamp_bits(x + a, 13);        // bits 17:13
		g6   = clamp_bits(x - g1 - g2, 12);  // bits 17:12
		b5   = clamp_bits(x + bc, 13);
		gray = 5'(r5 / 4 + g6 / 4 + b5 / 8);
		return {gray, gray, 1'b0, gray};
	endfunction

	// --------------------
	// stimulus
	task automatic drive_field(input string name, input logic odd_v);
		vbyte_t line_b [4 * PAIRS];
		word_t  words [$];
		int     irq0_n;
		int     irq1_n;
		irq0_n = 0;
		irq1_n = 0;
		next_cycle();
		vref = 1'b1;
		odd  = odd_v;
		repeat (4) next_cycle();         // field state settles before line 0
		for (int ln = 0; ln < LINES; ln++)
		begin
			for (int nb = 0; nb < 4 * PAIRS; nb++)
			begin
				line_b[nb] = vbyte_t'($urandom());
				href = 1'b1;
				vpo  = line_b[nb];
				next_cycle();
			end
			href = 1'b0;
			if (ln % 2 == 0)             // even pairs of even lines
				for (int p = 0; p < PAIRS; p += 2)
					words.push_back(model_pixel(line_b[4*p], line_b[4*p+1], line_b[4*p+2]));
			repeat (8) next_cycle();     // horizontal blank
		end
		vref = 1'b0;
		repeat (10)
		begin
			@(negedge clk_llc);
			irq0_n += irq0;
			irq1_n += irq1;
		end
		if (odd_v)
		begin
			for (int i = 0; i < KEPT_WORDS; i++)
				bank_exp[fill_bank][i] = words[i];
			done_bank = fill_bank;
			fill_bank = ~fill_bank;
		end
		check_value({name, " irq0"}, (odd_v && done_bank) ? 2 : 0, irq0_n);
		check_value({name, " irq1"}, (odd_v && !done_bank) ? 2 : 0, irq1_n);
	endtask

	task automatic read_word(input haddr_t a, output word_t d);
		int waited;
		waited = 0;
		next_cycle();
		haddr = a;
		csx   = 1'b0;
		rdx   = 1'b0;
		@(negedge clk_llc);
		while (!waitx)
		begin
			waited++;
			if (waited > READ_LIMIT)
				abort_run($sformatf("host read of address %0d never raised waitx", a));
			@(negedge clk_llc);
		end
		d = rd_data;
		next_cycle();
		csx = 1'b1;                      // end of access
		rdx = 1'b1;
	endtask

	task automatic readback_bank(input string name, input logic bank);
		word_t d;
		for (int i = 0; i < KEPT_WORDS; i++)
		begin
			read_word(haddr_t'(i), d);
			check_value(name, bank_exp[bank][i], d);
		end
	endtask

	// --------------------
	// directed tests
	task automatic test_reset_state();
		@(negedge clk_llc);
		check_value("reset waitx", 1, waitx);
		check_value("reset irq0", 0, irq0);
		check_value("reset irq1", 0, irq1);
		check_value("reset rd_data", 0, rd_data);
	endtask

	task automatic test_capture_readback();
		drive_field("capture", 1'b1);
		readback_bank("capture readback", 1'b0);
	endtask

	task automatic test_bank_alternation();
		drive_field("alternation bank 1", 1'b1);     // irq0
		readback_bank("alternation readback 1", 1'b1);
		drive_field("alternation bank 0", 1'b1);     // irq1
		readback_bank("alternation readback 0", 1'b0);
	endtask

	task automatic test_read_during_capture();
		word_t prev [KEPT_WORDS];
		word_t d;
		prev = bank_exp[done_bank];      // host still sees this bank
		fork
			drive_field("read during capture", 1'b1);
			begin
				repeat (40) next_cycle();    // well inside the first lines
				for (int i = 0; i < KEPT_WORDS; i++)
				begin
					read_word(haddr_t'(i), d);
					check_value("read during capture", prev[i], d);
				end
			end
		join
	endtask

	task automatic test_ignored_field();
		drive_field("ignored field", 1'b0);          // even field raises no irq
		readback_bank("ignored field readback", done_bank);
	endtask

	initial
	begin
		resetx    = 1'b0;
		vref      = 1'b0;
		href      = 1'b0;
		odd       = 1'b0;
		vpo       = '0;
		csx       = 1'b1;
		rdx       = 1'b1;
		haddr     = '0;
		fill_bank = 1'b0;
		done_bank = 1'b0;
		void'($urandom(32'hf5d7_d36e));
		repeat (4) @(posedge clk_llc);
		#2;
		resetx = 1'b1;
		test_reset_state();
		test_capture_readback();
		test_bank_alternation();
		test_read_during_capture();
		test_ignored_field();
		repeat (4) next_cycle();
		if (DUT.u_asserts.fail_cnt != 0)
			abort_run("a protocol assertion failed during the run");
		else
		begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

//--- project.f
hw/video_pkg.sv
hw/membus_pkg.sv
hw/capture_timing.sv
hw/ycbcr_convert.sv
hw/frame_writer.sv
hw/mem_arbiter.sv
hw/frame_ram.sv
hw/video_capture_top.sv
bench/video_capture_asserts.sv
bench/tb_video_capture.sv
